/* tests/wh_stream_patterns.hex */
// packet count, then per packet header flit 0, header flit 1 and len-1 data flits
// flit 0 holds pr_hdr[15:0], len, cord from the top down, flit 1 holds pr_hdr[47:16]
00000005
// cord 3a, len 02, one data flit
beef023a
12345678
a5a55a5a
// cord 07, len 04, three data flits
c0de0407
0badf00d
11112222
33334444
deadbeef
// cord 91, len 03, two data flits
7e570391
cafe0001
0f0ff0f0
80017ffe
// cord 00, len 02, one data flit
00000200
ffffffff
0000ffff
// cord ff, len 05, four data flits
5a5a05ff
a5a5a5a5
01234567
89abcdef
fedcba98
76543210

/* src.f */
rtl/wh_proto_pkg.sv
rtl/wh_link_pkg.sv
rtl/wh_flit_if.sv
rtl/wh_stream_control.sv
rtl/wh_hdr_sipo.sv
rtl/wh_data_piso.sv
rtl/wh_stream_out.sv
tests/tb_wh_stream_out.sv

/* Bender.yml */
package:
  name: wh_stream_out

sources:
  # packages first, the link package imports the protocol package
  - files:
      - rtl/wh_proto_pkg.sv
      - rtl/wh_link_pkg.sv
      - rtl/wh_flit_if.sv
      - rtl/wh_stream_control.sv
      - rtl/wh_hdr_sipo.sv
      - rtl/wh_data_piso.sv
      - rtl/wh_stream_out.sv

  - target: test
    files:
      - tests/tb_wh_stream_out.sv

/* tests/tb_wh_stream_out.sv */
`timescale 1ns/1ps

// drives wormhole packets from the pattern file into the egress adapter
// and checks the header stream and the beat stream against the same records
module tb_wh_stream_out
  import wh_link_pkg::*;
  import wh_proto_pkg::*;
();

  localparam int beats_per_flit_lp = flit_width_lp / pr_data_width_lp;
  localparam int reset_cycles_lp = 8;

  logic     clk_i = 1'b0;
  logic     rst_n_i;
  flit_t    link_data_i;
  logic     link_v_i;
  logic     link_ready_o;
  wh_hdr_u  hdr_o;
  logic     hdr_v_o;
  logic     hdr_ready_i;
  pr_data_t data_o;
  logic     data_v_o;
  logic     data_ready_i;

  // raw pattern words with the packet count in the first one
  flit_t pat_mem [0:63];

  // link flits in send order and the idle cycles before each
  flit_t link_q [$];
  int gap_q [$];

  // expected header flits, beats and beats per packet
  flit_t exp_w0_q [$];
  flit_t exp_w1_q [$];
  pr_data_t exp_beat_q [$];
  int exp_pkt_beats_q [$];

  int pkt_total;
  int beat_total;
  int hdr_seen;
  int beat_seen;
  int beats_in_pkt;
  int cycle_limit;
  integer seed;
  logic [31:0] rnd;
  logic loaded;

  // outputs seen stalled at the last falling edge
  logic hdr_stall_r;
  logic data_stall_r;
  wh_hdr_u hdr_held;
  pr_data_t data_held;

  wh_stream_out dut_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .link_data_i  (link_data_i),
    .link_v_i     (link_v_i),
    .link_ready_o (link_ready_o),
    .hdr_o        (hdr_o),
    .hdr_v_o      (hdr_v_o),
    .hdr_ready_i  (hdr_ready_i),
    .data_o       (data_o),
    .data_v_o     (data_v_o),
    .data_ready_i (data_ready_i)
  );

  always #10 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    begin
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // header is checked lane by lane and then field by field
  // the field values are cut straight from the raw words
  task automatic match_header(input string name, input wh_hdr_u got,
                              input flit_t w0, input flit_t w1);
    logic [cord_width_lp-1:0] exp_cord;
    logic [len_width_lp-1:0] exp_len;
    pr_hdr_t exp_pr;
    begin
      exp_cord = w0[cord_width_lp-1:0];
      exp_len = w0[cord_width_lp +: len_width_lp];
      // protocol info is the top of flit 0 followed by all of flit 1
      exp_pr = {w1, w0[flit_width_lp-1:cord_width_lp+len_width_lp]};
      if (got.flits[0] !== w0)
        abort_run($sformatf("Fail %s.flits[0]: got 0x%h expected 0x%h",
                            name, got.flits[0], w0));
      if (got.flits[1] !== w1)
        abort_run($sformatf("Fail %s.flits[1]: got 0x%h expected 0x%h",
                            name, got.flits[1], w1));
      if (got.fields.cord !== exp_cord)
        abort_run($sformatf("Fail %s.cord: got 0x%h expected 0x%h",
                            name, got.fields.cord, exp_cord));
      if (got.fields.len !== exp_len)
        abort_run($sformatf("Fail %s.len: got 0x%h expected 0x%h",
                            name, got.fields.len, exp_len));
      if (got.fields.pr_hdr !== exp_pr)
        abort_run($sformatf("Fail %s.pr_hdr: got 0x%h expected 0x%h",
                            name, got.fields.pr_hdr, exp_pr));
    end
  endtask

  task automatic match_beat(input string name, input pr_data_t got, input pr_data_t exp);
    begin
      if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // single strobes are compared four-state so an unknown level is caught
  task automatic compare_flag(input string name, input logic got, input logic exp);
    begin
      if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic verify_count(input string name, input int got, input int exp);
    begin
      if (got != exp)
        abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // client ready lines stall at random once reset is over
  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      #2;
      rnd = $random(seed);
      hdr_ready_i = (rnd[1:0] != 2'b00);
      data_ready_i = (rnd[4:2] > 3'd1);
    end
  end

  // outputs are sampled at the falling edge, where they have settled
  // valid and ready seen here are the ones the next rising edge uses
  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      compare_flag("hdr_v_o", hdr_v_o, 1'b0);
      compare_flag("data_v_o", data_v_o, 1'b0);
      compare_flag("link_ready_o", link_ready_o, 1'b0);
    end
    else
    begin
      if (!link_v_i)
        compare_flag("link_ready_o", link_ready_o, 1'b0);
      // a stalled output must still be offered with the same value
      if (hdr_stall_r)
      begin
        compare_flag("hdr_v_o", hdr_v_o, 1'b1);
        match_header("hdr_o", hdr_o, hdr_held.flits[0], hdr_held.flits[1]);
      end
      if (data_stall_r)
      begin
        compare_flag("data_v_o", data_v_o, 1'b1);
        match_beat("data_o", data_o, data_held);
      end
      if (hdr_v_o && hdr_ready_i)
      begin
        // the packet before this header has to be complete
        if (hdr_seen > 0)
          verify_count("beats in packet", beats_in_pkt, exp_pkt_beats_q[hdr_seen-1]);
        if (exp_w0_q.size() == 0)
          abort_run("a header was accepted after all packets were done");
        match_header("hdr_o", hdr_o, exp_w0_q.pop_front(), exp_w1_q.pop_front());
        hdr_seen = hdr_seen + 1;
        beats_in_pkt = 0;
      end
      if (data_v_o && data_ready_i)
      begin
        if (hdr_seen == 0)
          abort_run("a data beat was accepted before any header");
        if (exp_beat_q.size() == 0)
          abort_run("more data beats came out than the patterns hold");
        match_beat("data_o", data_o, exp_beat_q.pop_front());
        beats_in_pkt = beats_in_pkt + 1;
        beat_seen = beat_seen + 1;
      end
    end
    hdr_stall_r = rst_n_i & hdr_v_o & ~hdr_ready_i;
    data_stall_r = rst_n_i & data_v_o & ~data_ready_i;
    hdr_held = hdr_o;
    data_held = data_o;
  end

  // allows 200 cycles for every flit in the pattern file
  initial
  begin
    wait (loaded);
    cycle_limit = 200 * link_q.size() + reset_cycles_lp;
    repeat (cycle_limit) @(posedge clk_i);
    abort_run("timeout: the packets did not drain through the adapter in time");
  end

  initial
  begin : main_flow
    int idx;
    int p;
    int d;
    int b;
    int k;
    int n_data;
    flit_t w0;
    flit_t w1;
    flit_t dflit;
    logic accepted;

    rst_n_i = 1'b0;
    link_data_i = '0;
    link_v_i = 1'b0;
    hdr_ready_i = 1'b0;
    data_ready_i = 1'b0;
    seed = 32'h64c8_de76;
    loaded = 1'b0;
    hdr_seen = 0;
    beat_seen = 0;
    beats_in_pkt = 0;
    hdr_stall_r = 1'b0;
    data_stall_r = 1'b0;

    $readmemh("tests/wh_stream_patterns.hex", pat_mem);
    pkt_total = int'(pat_mem[0]);
    idx = 1;
    for (p = 0; p < pkt_total; p++)
    begin
      w0 = pat_mem[idx];
      w1 = pat_mem[idx+1];
      if ($isunknown(w0) || $isunknown(w1))
        abort_run("the pattern file ends inside a header");
      link_q.push_back(w0);
      link_q.push_back(w1);
      exp_w0_q.push_back(w0);
      exp_w1_q.push_back(w1);
      // len counts every flit after the first, the rest of the header included
      n_data = int'(w0[cord_width_lp +: len_width_lp]) + 1 - hdr_flits_lp;
      if (n_data < 1)
        abort_run("a packet in the pattern file has no data flit");
      exp_pkt_beats_q.push_back(beats_per_flit_lp * n_data);
      idx = idx + 2;
      for (d = 0; d < n_data; d++)
      begin
        dflit = pat_mem[idx];
        if ($isunknown(dflit))
          abort_run("the pattern file ends inside a packet");
        link_q.push_back(dflit);
        // beats leave low slice first
        for (b = 0; b < beats_per_flit_lp; b++)
          exp_beat_q.push_back(dflit[b*pr_data_width_lp +: pr_data_width_lp]);
        idx = idx + 1;
      end
    end
    beat_total = exp_beat_q.size();

    // mostly no idle cycles between link flits
    for (k = 0; k < link_q.size(); k++)
    begin
      rnd = $random(seed);
      gap_q.push_back((rnd[2:0] < 3'd5) ? 0 : int'(rnd[4:3]) + 1);
    end
    loaded = 1'b1;

    repeat (reset_cycles_lp) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    for (k = 0; k < link_q.size(); k++)
    begin
      repeat (gap_q[k])
      begin
        @(posedge clk_i);
        #2;
      end
      link_v_i = 1'b1;
      link_data_i = link_q[k];
      accepted = 1'b0;
      // the flit stays on the link until the adapter takes it
      while (!accepted)
      begin
        @(negedge clk_i);
        accepted = link_ready_o;
      end
      @(posedge clk_i);
      #2;
      link_v_i = 1'b0;
    end

    verify_count("header count", hdr_seen, pkt_total);
    verify_count("beats in packet", beats_in_pkt, exp_pkt_beats_q[pkt_total-1]);
    verify_count("beat count", beat_seen, beat_total);
    if (exp_beat_q.size() != 0)
    begin
      abort_run("some expected data beats never came out");
    end
    else
    begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

/* rtl/wh_stream_out.sv */
`timescale 1ns/1ps

// wormhole egress adapter
// link flits come in, a header word and a stream of narrow data beats go out
module wh_stream_out
  import wh_link_pkg::*;
  import wh_proto_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // wormhole link side
  input  flit_t    link_data_i,
  input  logic     link_v_i,
  output logic     link_ready_o,

  // combined wormhole and protocol header
  output wh_hdr_u  hdr_o,
  output logic     hdr_v_o,
  input  logic     hdr_ready_i,

  // protocol data beats, low slice of each flit first
  output pr_data_t data_o,
  output logic     data_v_o,
  input  logic     data_ready_i
);

  // beats per flit, data is never wider than a flit here
  localparam int beats_lp = flit_width_lp / pr_data_width_lp;

  wh_flit_if #(.flit_width_p(flit_width_lp)) flit_if ();

  // splits the link into header and data phases
  wh_stream_control #(
    .hdr_len_p (hdr_flits_lp)
  ) stream_control (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .link_data_i  (link_data_i),
    .link_v_i     (link_v_i),
    .link_ready_o (link_ready_o),
    .flit_o       (flit_if.ctrl)
  );

  wh_hdr_sipo #(
    .flit_width_p (flit_width_lp),
    .els_p        (hdr_flits_lp)
  ) hdr_sipo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flit_i      (flit_if.hdr_sink),
    .hdr_o       (hdr_o),
    .hdr_v_o     (hdr_v_o),
    .hdr_ready_i (hdr_ready_i)
  );

  wh_data_piso #(
    .flit_width_p (flit_width_lp),
    .els_p        (beats_lp)
  ) data_piso (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flit_i       (flit_if.data_sink),
    .data_o       (data_o),
    .data_v_o     (data_v_o),
    .data_ready_i (data_ready_i)
  );

endmodule

/* rtl/wh_data_piso.sv */
`timescale 1ns/1ps

// hands one data flit to the client as els_p narrower beats
// the flit stays on the link until its last beat is taken, so nothing is buffered
module wh_data_piso
  import wh_proto_pkg::*;
#(
  parameter int flit_width_p = 32,
  parameter int els_p        = 2
)
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  wh_flit_if.data_sink flit_i,
  output pr_data_t    data_o,
  output logic        data_v_o,
  input  logic        data_ready_i
);

  // width of a beat as seen from the flit side
  localparam int beat_width_lp = flit_width_p / els_p;
  localparam int idx_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam logic [idx_width_lp-1:0] last_idx_lp = idx_width_lp'(els_p - 1);
  localparam logic [idx_width_lp-1:0] idx_one_lp = idx_width_lp'(1);

  // slice of the current flit that is on data_o
  logic [idx_width_lp-1:0] idx_r;
  logic [els_p-1:0][beat_width_lp-1:0] slices;
  logic last_slice;
  logic beat_accept;

  // slice 0 is the low end of the flit
  assign slices = flit_i.flit;
  assign data_o = slices[idx_r];

  // a beat is valid for as long as the flit is
  assign data_v_o = flit_i.data_v;
  assign beat_accept = data_v_o & data_ready_i;

  assign last_slice = (idx_r == last_idx_lp);

  // the link only advances together with the final beat
  // so each flit holds the link for at least els_p cycles
  assign flit_i.data_ready = flit_i.data_v & data_ready_i & last_slice;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      idx_r <= '0;
    end
    else if (beat_accept)
    begin
      // wrapping here also releases the flit on the same edge
      idx_r <= last_slice ? '0 : (idx_r + idx_one_lp);
    end
  end

endmodule

/* rtl/wh_hdr_sipo.sv */
`timescale 1ns/1ps

// gathers header flits into one header word
// the first els_p-1 flits are stored and the final one goes straight to the client
module wh_hdr_sipo
  import wh_link_pkg::*;
#(
  parameter int flit_width_p = 32,
  parameter int els_p        = 2
)
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  wh_flit_if.hdr_sink flit_i,
  output wh_hdr_u    hdr_o,
  output logic       hdr_v_o,
  input  logic       hdr_ready_i
);

  localparam int fill_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  // lane index of the flit that completes the header
  localparam logic [fill_width_lp-1:0] last_lane_lp = fill_width_lp'(els_p - 1);
  localparam logic [fill_width_lp-1:0] fill_one_lp = fill_width_lp'(1);

  // number of flits already held in the bank
  logic [fill_width_lp-1:0] fill_r;
  logic [els_p-2:0][flit_width_p-1:0] bank_r;
  logic [els_p-1:0][flit_width_p-1:0] hdr_lanes;
  logic full;
  logic hdr_accept;

  assign full = (fill_r == last_lane_lp);

  // storage takes a flit whenever it has room
  // on the last flit the link waits for the client instead
  assign flit_i.hdr_ready = flit_i.hdr_v & (full ? hdr_ready_i : 1'b1);
  assign hdr_accept = flit_i.hdr_v & flit_i.hdr_ready;

  // header is offered in the same cycle as its last flit
  assign hdr_v_o = flit_i.hdr_v & full;

  // top lane bypasses the bank and the lower lanes come from it
  assign hdr_lanes[els_p-1] = flit_i.flit;
  assign hdr_lanes[els_p-2:0] = bank_r;
  assign hdr_o.flits = hdr_lanes;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      fill_r <= '0;
    end
    else if (hdr_accept)
    begin
      // wraps once the client has taken the whole header
      fill_r <= full ? '0 : (fill_r + fill_one_lp);
    end
  end

  // each lower lane is written by the header flit that belongs to it
  always_ff @(posedge clk_i)
  begin
    if (hdr_accept && !full)
    begin
      bank_r[fill_r] <= flit_i.flit;
    end
  end

  // the bank is frozen and the link holds its flit while the client stalls
  a_hdr_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (hdr_v_o && !hdr_ready_i) |=> $stable(hdr_o)
  );

endmodule

/* rtl/wh_stream_control.sv */
`timescale 1ns/1ps

// tracks where in a wormhole packet the next link flit falls
// the first hdr_len_p flits go to the header collector, the rest to the data splitter
module wh_stream_control
  import wh_link_pkg::*;
#(
  parameter int hdr_len_p = 2
)
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  flit_t      link_data_i,
  input  logic       link_v_i,
  output logic       link_ready_o,
  wh_flit_if.ctrl    flit_o
);

  // the header counter must be able to hold hdr_len_p itself
  localparam int hcnt_width_lp = $clog2(hdr_len_p + 1);
  localparam logic [hcnt_width_lp-1:0] hdr_len_lp = hcnt_width_lp'(hdr_len_p);
  localparam logic [hcnt_width_lp-1:0] hcnt_one_lp = hcnt_width_lp'(1);
  localparam logic [len_width_lp-1:0] len_one_lp = len_width_lp'(1);

  // flits still owed after the last accepted one
  logic [len_width_lp-1:0] cnt_r;
  // header flits accepted so far, zero means the next flit opens a packet
  logic [hcnt_width_lp-1:0] hcnt_r;

  logic [len_width_lp-1:0] len_li;
  logic first_flit;
  logic is_hdr;
  logic last_flit;
  logic link_accept;

  // len is only meaningful on the first flit, it sits just above cord
  assign len_li = link_data_i[cord_width_lp +: len_width_lp];

  assign first_flit = (hcnt_r == '0);
  // stays in header phase until hdr_len_p header flits have gone by
  assign is_hdr = (hcnt_r < hdr_len_lp);
  // every packet ends on a data flit, never on the first one
  assign last_flit = ~first_flit & (cnt_r == len_one_lp);
  assign link_accept = link_v_i & link_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_r  <= '0;
      hcnt_r <= '0;
    end
    else if (link_accept)
    begin
      if (first_flit)
      begin
        // load the packet length and count the first header flit
        cnt_r  <= len_li;
        hcnt_r <= hcnt_one_lp;
      end
      else
      begin
        cnt_r <= cnt_r - len_one_lp;
        if (last_flit)
        begin
          // back to header phase on the edge that takes the last flit
          hcnt_r <= '0;
        end
        else if (is_hdr)
        begin
          hcnt_r <= hcnt_r + hcnt_one_lp;
        end
      end
    end
  end

  // the flit itself is shared, only the strobes are steered
  assign flit_o.flit   = link_data_i;
  assign flit_o.hdr_v  = link_v_i & is_hdr;
  assign flit_o.data_v = link_v_i & ~is_hdr;

  // ready comes from whichever sink owns the current phase
  assign link_ready_o = is_hdr ? flit_o.hdr_ready : flit_o.data_ready;

  // a packet must carry at least one data flit past its header
  a_len_covers_hdr: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (link_v_i && first_flit) |-> (len_li >= len_width_lp'(hdr_len_p))
  );

  // both sinks gate their ready with valid, so the link never sees a bare ready
  a_ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    link_ready_o |-> link_v_i
  );

endmodule

/* rtl/wh_flit_if.sv */
`timescale 1ns/1ps

// carries the incoming flit from the control block to both datapath sinks
// the control block splits link valid into a header strobe and a data strobe
// and each sink answers on its own ready line
interface wh_flit_if
#(
  parameter int flit_width_p = 32
);

  // link data, passed straight through without a register
  logic [flit_width_p-1:0] flit;

  // link valid qualified by the phase of the packet
  // at most one of these is high in any cycle
  logic hdr_v;
  logic data_v;

  // sink side acceptance, each only meaningful with its own valid
  logic hdr_ready;
  logic data_ready;

  // the control block owns the strobes and reads back both readies
  modport ctrl (
    output flit,
    output hdr_v,
    output data_v,
    input  hdr_ready,
    input  data_ready
  );

  // header collector only looks at the header strobe
  modport hdr_sink (
    input  flit,
    input  hdr_v,
    output hdr_ready
  );

  // data splitter only looks at the data strobe
  modport data_sink (
    input  flit,
    input  data_v,
    output data_ready
  );

endinterface

/* rtl/wh_link_pkg.sv */
package wh_link_pkg;

  import wh_proto_pkg::*;

  // physical width of the wormhole link
  localparam int flit_width_lp = 32;

  // destination coordinate at the very bottom of the first flit
  localparam int cord_width_lp = 8;

  // len counts the flits that follow the first flit of a packet
  localparam int len_width_lp = 8;

  // flits that together make up one header word
  // cord + len + protocol info must fill exactly this many flits
  localparam int hdr_flits_lp = 2;

  // one word as it travels on the link
  typedef logic [flit_width_lp-1:0] flit_t;

  // header fields, listed from the top bit down
  // so cord sits at bit 0, len right above it, protocol info on top
  typedef struct packed {
    pr_hdr_t                  pr_hdr;
    logic [len_width_lp-1:0]  len;
    logic [cord_width_lp-1:0] cord;
  } wh_hdr_s;

  // the same 64 bits seen two ways
  // the collector fills it one flit lane at a time
  // the client picks it apart by field
  // flits[0] is the first flit received and overlays cord and len
  typedef union packed {
    wh_hdr_s                    fields;
    flit_t [hdr_flits_lp-1:0]   flits;
  } wh_hdr_u;

endpackage

/* rtl/wh_proto_pkg.sv */
package wh_proto_pkg;

  // widths of the client protocol carried inside wormhole packets

  // protocol header bits that follow the cord and len fields of the first flit
  localparam int pr_hdr_width_lp = 48;

  // a single protocol data beat as the client sees it
  // several of these are packed into one link flit, low beat first
  localparam int pr_data_width_lp = 16;

  // protocol info field of the combined header word
  // the bit meaning belongs to the client, this block only moves it
  typedef logic [pr_hdr_width_lp-1:0] pr_hdr_t;

  // one beat on the data stream
  typedef logic [pr_data_width_lp-1:0] pr_data_t;

endpackage
